//--- common/rtu_defines.svh
`ifndef RTU_DEFINES_SVH
`define RTU_DEFINES_SVH

//--------------------------------------------------------------------------
// Datapath widths
//--------------------------------------------------------------------------

// Physical address width for PCs and tval
`define RTU_PA_WIDTH    40

// Exception vector width
`define RTU_VEC_WIDTH   5

// Number of completion sources in ex1
`define RTU_CBUS_WIDTH  7

//--------------------------------------------------------------------------
// One-hot completion source codes
//--------------------------------------------------------------------------

// ALU is the top bit, VEC is bit 0
`define RTU_CBUS_ALU_SEL  7'b100_0000
`define RTU_CBUS_MUL_SEL  7'b010_0000
`define RTU_CBUS_BJU_SEL  7'b001_0000
`define RTU_CBUS_DIV_SEL  7'b000_1000
`define RTU_CBUS_LSU_SEL  7'b000_0100
`define RTU_CBUS_CP0_SEL  7'b000_0010
`define RTU_CBUS_VEC_SEL  7'b000_0001

`endif

//--- common/rtu_pkg.sv
`include "rtu_defines.svh"

package rtu_pkg;

  //------------------------------------------------------------------------
  // Scalar datapath types
  //------------------------------------------------------------------------

  // PC or trap value
  typedef logic [`RTU_PA_WIDTH-1:0] pc_t;

  // Exception vector number
  typedef logic [`RTU_VEC_WIDTH-1:0] expt_vec_t;

  //------------------------------------------------------------------------
  // Completion source
  //------------------------------------------------------------------------

  // Field order follows the one-hot select codes
  typedef struct packed {
    logic alu;
    logic mul;
    logic bju;
    logic div;
    logic lsu;
    logic cp0;
    logic vec;
  } cmplt_src_s;

  // Raw view for decode and reduction, named view for single units
  typedef union packed {
    logic [`RTU_CBUS_WIDTH-1:0] raw;
    cmplt_src_s                 unit;
  } cmplt_src_u;

endpackage

//--- logic/retire_ctrl.sv
`timescale 1ns/1ps

module retire_ctrl (
  input  logic               dp_misc_clk,
  input  logic               rst_n,

  // Unit completion reports from ex1
  input  logic               alu_cmplt,
  input  logic               mul_cmplt,
  input  logic               bju_cmplt,
  input  logic               div_cmplt,
  input  logic               lsu_cmplt,
  input  logic               cp0_cmplt,
  input  logic               vec_cmplt,

  output rtu_pkg::cmplt_src_u cmplt_src,
  output logic               pipe_en,
  output logic               trap_en,
  output logic               ex2_vld
);

  //------------------------------------------------------------------------
  // Completion source vector
  //------------------------------------------------------------------------

  // At most one unit reports per cycle
  assign cmplt_src.raw = {alu_cmplt,
                          mul_cmplt,
                          bju_cmplt,
                          div_cmplt,
                          lsu_cmplt,
                          cp0_cmplt,
                          vec_cmplt};

  //------------------------------------------------------------------------
  // Stage enables
  //------------------------------------------------------------------------

  // Any completion moves the instruction into ex2
  assign pipe_en = |cmplt_src.raw;

  // Only CP0 and LSU carry trap information
  assign trap_en = cmplt_src.unit.cp0 | cmplt_src.unit.lsu;

  //------------------------------------------------------------------------
  // Ex2 valid
  //------------------------------------------------------------------------

  always_ff @(posedge dp_misc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex2_vld <= 1'b0;
    end else begin
      ex2_vld <= pipe_en;
    end
  end

endmodule

//--- logic/cmplt_decode.sv
`timescale 1ns/1ps

`include "rtu_defines.svh"

module cmplt_decode (
  input  logic                dp_misc_clk,
  input  logic                rst_n,
  input  rtu_pkg::cmplt_src_u cmplt_src,
  input  logic                pipe_en,

  // Integer unit info
  input  logic                alu_inst_len,
  input  logic                alu_inst_split,
  input  logic                bju_inst_len,
  input  logic                branch_inst,

  // LSU info
  input  logic                lsu_inst_len,
  input  logic                lsu_inst_split,

  // CP0 info
  input  logic                cp0_inst_len,
  input  logic                cp0_inst_split,
  input  logic                cp0_mret,
  input  logic                cp0_sret,
  input  logic                cp0_flush,

  output logic                ex1_inst_len,
  output logic                ex1_inst_split,

  output logic                ex2_inst_split,
  output logic                ex2_inst_branch,
  output logic                ex2_inst_mret,
  output logic                ex2_inst_sret,
  output logic                ex2_inst_flush
);

  logic ex1_inst_branch;
  logic ex1_inst_mret;
  logic ex1_inst_sret;
  logic ex1_inst_flush;

  //------------------------------------------------------------------------
  // Ex1 length and split decode
  //------------------------------------------------------------------------

  always_comb begin
    case (cmplt_src.raw)
      `RTU_CBUS_ALU_SEL: begin
        ex1_inst_len   = alu_inst_len;
        ex1_inst_split = alu_inst_split;
      end
      `RTU_CBUS_BJU_SEL: begin
        ex1_inst_len   = bju_inst_len;
        ex1_inst_split = 1'b0;
      end
      `RTU_CBUS_LSU_SEL: begin
        ex1_inst_len   = lsu_inst_len;
        ex1_inst_split = lsu_inst_split;
      end
      `RTU_CBUS_CP0_SEL: begin
        ex1_inst_len   = cp0_inst_len;
        ex1_inst_split = cp0_inst_split;
      end
      // Fixed 32-bit, never split
      `RTU_CBUS_MUL_SEL, `RTU_CBUS_DIV_SEL, `RTU_CBUS_VEC_SEL: begin
        ex1_inst_len   = 1'b1;
        ex1_inst_split = 1'b0;
      end
      default: begin
        ex1_inst_len   = 1'b0;
        ex1_inst_split = 1'b0;
      end
    endcase
  end

  // Class flags qualified by the owning unit
  assign ex1_inst_branch = cmplt_src.unit.bju & branch_inst;
  assign ex1_inst_mret   = cmplt_src.unit.cp0 & cp0_mret;
  assign ex1_inst_sret   = cmplt_src.unit.cp0 & cp0_sret;
  assign ex1_inst_flush  = cmplt_src.unit.cp0 & cp0_flush;

  //------------------------------------------------------------------------
  // Ex2 flag registers
  //------------------------------------------------------------------------

  always_ff @(posedge dp_misc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex2_inst_split  <= 1'b0;
      ex2_inst_branch <= 1'b0;
      ex2_inst_mret   <= 1'b0;
      ex2_inst_sret   <= 1'b0;
      ex2_inst_flush  <= 1'b0;
    end else if (pipe_en) begin
      ex2_inst_split  <= ex1_inst_split;
      ex2_inst_branch <= ex1_inst_branch;
      ex2_inst_mret   <= ex1_inst_mret;
      ex2_inst_sret   <= ex1_inst_sret;
      ex2_inst_flush  <= ex1_inst_flush;
    end
  end

endmodule

//--- logic/pc_select.sv
`timescale 1ns/1ps

module pc_select (
  input  logic                dp_misc_clk,
  input  logic                rst_n,
  input  rtu_pkg::cmplt_src_u cmplt_src,
  input  logic                pipe_en,

  // Ex1 PCs
  input  rtu_pkg::pc_t        ex1_cur_pc,
  input  rtu_pkg::pc_t        ex1_next_pc,
  input  rtu_pkg::pc_t        cp0_chgflw_pc,
  input  logic                cp0_chgflw,

  // Late load-dependent redirect at ex2
  input  logic                depd_lsu_chgflw_vld,
  input  rtu_pkg::pc_t        depd_lsu_next_pc,

  output rtu_pkg::pc_t        ex2_cur_pc,
  output rtu_pkg::pc_t        ex2_next_pc,
  output logic                ex2_inst_chgflw
);

  logic         ex1_inst_chgflw;
  rtu_pkg::pc_t ex1_sel_next_pc;
  rtu_pkg::pc_t ex2_next_pc_q;

  //------------------------------------------------------------------------
  // Ex1 next-PC selection
  //------------------------------------------------------------------------

  // CP0 redirect wins over the sequential PC
  assign ex1_inst_chgflw = cmplt_src.unit.cp0 & cp0_chgflw;
  assign ex1_sel_next_pc = ex1_inst_chgflw ? cp0_chgflw_pc : ex1_next_pc;

  //------------------------------------------------------------------------
  // Ex2 PC registers
  //------------------------------------------------------------------------

  always_ff @(posedge dp_misc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex2_cur_pc      <= '0;
      ex2_next_pc_q   <= '0;
      ex2_inst_chgflw <= 1'b0;
    end else if (pipe_en) begin
      ex2_cur_pc      <= ex1_cur_pc;
      ex2_next_pc_q   <= ex1_sel_next_pc;
      ex2_inst_chgflw <= ex1_inst_chgflw;
    end
  end

  // Load-dependent redirect arrives too late to register
  assign ex2_next_pc = depd_lsu_chgflw_vld ? depd_lsu_next_pc : ex2_next_pc_q;

endmodule

//--- trap/trap_capture.sv
`timescale 1ns/1ps

module trap_capture (
  input  logic                dp_misc_clk,
  input  logic                rst_n,
  input  rtu_pkg::cmplt_src_u cmplt_src,
  input  logic                trap_en,

  // CP0 exception report
  input  logic                cp0_expt_vld,
  input  rtu_pkg::expt_vec_t  cp0_expt_vec,
  input  rtu_pkg::pc_t        cp0_expt_tval,

  // LSU exception report
  input  logic                lsu_expt_vld,
  input  rtu_pkg::expt_vec_t  lsu_expt_vec,
  input  rtu_pkg::pc_t        lsu_expt_tval,

  output logic                ex2_inst_expt,
  output rtu_pkg::expt_vec_t  ex2_vec,
  output rtu_pkg::pc_t        ex2_tval
);

  logic               ex1_inst_expt;
  rtu_pkg::expt_vec_t ex1_vec;
  rtu_pkg::pc_t       ex1_tval;

  //------------------------------------------------------------------------
  // Ex1 exception selection
  //------------------------------------------------------------------------

  // Each valid counts only while its own unit completes
  assign ex1_inst_expt = (cmplt_src.unit.cp0 & cp0_expt_vld)
                       | (cmplt_src.unit.lsu & lsu_expt_vld);

  // CP0 takes priority, LSU otherwise
  assign ex1_vec  = cmplt_src.unit.cp0 ? cp0_expt_vec  : lsu_expt_vec;
  assign ex1_tval = cmplt_src.unit.cp0 ? cp0_expt_tval : lsu_expt_tval;

  //------------------------------------------------------------------------
  // Ex2 trap registers
  //------------------------------------------------------------------------

  // Hold through completions that carry no trap info
  always_ff @(posedge dp_misc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ex2_inst_expt <= 1'b0;
      ex2_vec       <= '0;
      ex2_tval      <= '0;
    end else if (trap_en) begin
      ex2_inst_expt <= ex1_inst_expt;
      ex2_vec       <= ex1_vec;
      ex2_tval      <= ex1_tval;
    end
  end

endmodule

//--- logic/rtu_dp_top.sv
`timescale 1ns/1ps

module rtu_dp_top (
  input  logic               dp_misc_clk,
  input  logic               rst_n,

  // Integer unit, ex1
  input  logic               iu_rtu_ex1_alu_cmplt_dp,
  input  logic               iu_rtu_ex1_alu_inst_len,
  input  logic               iu_rtu_ex1_alu_inst_split,
  input  logic               iu_rtu_ex1_mul_cmplt_dp,
  input  logic               iu_rtu_ex1_bju_cmplt_dp,
  input  logic               iu_rtu_ex1_bju_inst_len,
  input  logic               iu_rtu_ex1_branch_inst,
  input  logic               iu_rtu_ex1_div_cmplt_dp,
  input  rtu_pkg::pc_t       iu_rtu_ex1_cur_pc,
  input  rtu_pkg::pc_t       iu_rtu_ex1_next_pc,
  input  logic               iu_rtu_depd_lsu_chgflow_vld,
  input  rtu_pkg::pc_t       iu_rtu_depd_lsu_next_pc,

  // Load/store unit, ex1
  input  logic               lsu_rtu_ex1_cmplt_dp,
  input  logic               lsu_rtu_ex1_inst_len,
  input  logic               lsu_rtu_ex1_inst_split,
  input  logic               lsu_rtu_ex1_expt_vld,
  input  rtu_pkg::expt_vec_t lsu_rtu_ex1_expt_vec,
  input  rtu_pkg::pc_t       lsu_rtu_ex1_expt_tval,

  // CP0, ex1
  input  logic               cp0_rtu_ex1_cmplt_dp,
  input  logic               cp0_rtu_ex1_inst_len,
  input  logic               cp0_rtu_ex1_inst_split,
  input  logic               cp0_rtu_ex1_inst_mret,
  input  logic               cp0_rtu_ex1_inst_sret,
  input  logic               cp0_rtu_ex1_flush,
  input  logic               cp0_rtu_ex1_chgflw,
  input  rtu_pkg::pc_t       cp0_rtu_ex1_chgflw_pc,
  input  logic               cp0_rtu_ex1_expt_vld,
  input  rtu_pkg::expt_vec_t cp0_rtu_ex1_expt_vec,
  input  rtu_pkg::pc_t       cp0_rtu_ex1_expt_tval,

  // Vector unit, ex1
  input  logic               vpu_rtu_ex1_cmplt_dp,

  // Same-cycle return to the integer unit
  output logic               rtu_iu_ex1_inst_len,
  output logic               rtu_iu_ex1_inst_split,

  // Ex2 retire info
  output logic               dp_retire_ex2_vld,
  output logic               dp_retire_ex2_inst_split,
  output logic               dp_retire_ex2_inst_branch,
  output logic               dp_retire_ex2_inst_mret,
  output logic               dp_retire_ex2_inst_sret,
  output logic               dp_retire_ex2_inst_flush,
  output logic               dp_retire_ex2_inst_chgflw,
  output rtu_pkg::pc_t       dp_retire_ex2_cur_pc,
  output rtu_pkg::pc_t       dp_retire_ex2_next_pc,
  output logic               dp_retire_ex2_inst_expt,
  output rtu_pkg::expt_vec_t dp_retire_ex2_vec,
  output rtu_pkg::pc_t       dp_retire_ex2_tval
);

  rtu_pkg::cmplt_src_u cmplt_src;
  logic                pipe_en;
  logic                trap_en;

  //--------------------------------------------------------------------------
  // Control
  //--------------------------------------------------------------------------

  retire_ctrl u_retire_ctrl (
    .dp_misc_clk (dp_misc_clk),
    .rst_n       (rst_n),
    .alu_cmplt   (iu_rtu_ex1_alu_cmplt_dp),
    .mul_cmplt   (iu_rtu_ex1_mul_cmplt_dp),
    .bju_cmplt   (iu_rtu_ex1_bju_cmplt_dp),
    .div_cmplt   (iu_rtu_ex1_div_cmplt_dp),
    .lsu_cmplt   (lsu_rtu_ex1_cmplt_dp),
    .cp0_cmplt   (cp0_rtu_ex1_cmplt_dp),
    .vec_cmplt   (vpu_rtu_ex1_cmplt_dp),
    .cmplt_src   (cmplt_src),
    .pipe_en     (pipe_en),
    .trap_en     (trap_en),
    .ex2_vld     (dp_retire_ex2_vld)
  );

  //--------------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------------

  cmplt_decode u_cmplt_decode (
    .dp_misc_clk     (dp_misc_clk),
    .rst_n           (rst_n),
    .cmplt_src       (cmplt_src),
    .pipe_en         (pipe_en),
    .alu_inst_len    (iu_rtu_ex1_alu_inst_len),
    .alu_inst_split  (iu_rtu_ex1_alu_inst_split),
    .bju_inst_len    (iu_rtu_ex1_bju_inst_len),
    .branch_inst     (iu_rtu_ex1_branch_inst),
    .lsu_inst_len    (lsu_rtu_ex1_inst_len),
    .lsu_inst_split  (lsu_rtu_ex1_inst_split),
    .cp0_inst_len    (cp0_rtu_ex1_inst_len),
    .cp0_inst_split  (cp0_rtu_ex1_inst_split),
    .cp0_mret        (cp0_rtu_ex1_inst_mret),
    .cp0_sret        (cp0_rtu_ex1_inst_sret),
    .cp0_flush       (cp0_rtu_ex1_flush),
    .ex1_inst_len    (rtu_iu_ex1_inst_len),
    .ex1_inst_split  (rtu_iu_ex1_inst_split),
    .ex2_inst_split  (dp_retire_ex2_inst_split),
    .ex2_inst_branch (dp_retire_ex2_inst_branch),
    .ex2_inst_mret   (dp_retire_ex2_inst_mret),
    .ex2_inst_sret   (dp_retire_ex2_inst_sret),
    .ex2_inst_flush  (dp_retire_ex2_inst_flush)
  );

  pc_select u_pc_select (
    .dp_misc_clk         (dp_misc_clk),
    .rst_n               (rst_n),
    .cmplt_src           (cmplt_src),
    .pipe_en             (pipe_en),
    .ex1_cur_pc          (iu_rtu_ex1_cur_pc),
    .ex1_next_pc         (iu_rtu_ex1_next_pc),
    .cp0_chgflw_pc       (cp0_rtu_ex1_chgflw_pc),
    .cp0_chgflw          (cp0_rtu_ex1_chgflw),
    .depd_lsu_chgflw_vld (iu_rtu_depd_lsu_chgflow_vld),
    .depd_lsu_next_pc    (iu_rtu_depd_lsu_next_pc),
    .ex2_cur_pc          (dp_retire_ex2_cur_pc),
    .ex2_next_pc         (dp_retire_ex2_next_pc),
    .ex2_inst_chgflw     (dp_retire_ex2_inst_chgflw)
  );

  trap_capture u_trap_capture (
    .dp_misc_clk   (dp_misc_clk),
    .rst_n         (rst_n),
    .cmplt_src     (cmplt_src),
    .trap_en       (trap_en),
    .cp0_expt_vld  (cp0_rtu_ex1_expt_vld),
    .cp0_expt_vec  (cp0_rtu_ex1_expt_vec),
    .cp0_expt_tval (cp0_rtu_ex1_expt_tval),
    .lsu_expt_vld  (lsu_rtu_ex1_expt_vld),
    .lsu_expt_vec  (lsu_rtu_ex1_expt_vec),
    .lsu_expt_tval (lsu_rtu_ex1_expt_tval),
    .ex2_inst_expt (dp_retire_ex2_inst_expt),
    .ex2_vec       (dp_retire_ex2_vec),
    .ex2_tval      (dp_retire_ex2_tval)
  );

endmodule

//--- verification/rtu_dp_assertions.sv
`timescale 1ns/1ps

module rtu_dp_assertions (
  input logic                dp_misc_clk,
  input logic                rst_n,
  input rtu_pkg::cmplt_src_u cmplt_src,
  input logic                pipe_en,
  input logic                ex2_vld
);

  // No two units complete in the same cycle
  property one_source_p;
    @(posedge dp_misc_clk) disable iff (!rst_n) $onehot0(cmplt_src.raw);
  endproperty

  // Ex2 valid trails pipe_en by one cycle
  property vld_follows_p;
    @(posedge dp_misc_clk) disable iff (!rst_n) ex2_vld == $past(pipe_en);
  endproperty

  one_source_a: assert property (one_source_p)
    else $error("More than one unit completed in the same cycle");
  vld_follows_a: assert property (vld_follows_p)
    else $error("ex2 valid did not follow pipe_en by one cycle");

endmodule

//--- verification/rtu_dp_tb.sv
`timescale 1ns/1ps

`include "rtu_defines.svh"

module rtu_dp_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int DRIVE_DELAY    = 2;
  localparam int RESET_CYCLES   = 8;
  localparam int NUM_CYCLES     = 600;
  // Reset, random cycles and a margin of several hundred cycles
  localparam int TIMEOUT_CYCLES = 1000;

  // Unit choice per cycle, 0 means no completion
  localparam logic [2:0] UNIT_NONE = 3'd0;
  localparam logic [2:0] UNIT_ALU  = 3'd1;
  localparam logic [2:0] UNIT_MUL  = 3'd2;
  localparam logic [2:0] UNIT_BJU  = 3'd3;
  localparam logic [2:0] UNIT_DIV  = 3'd4;
  localparam logic [2:0] UNIT_LSU  = 3'd5;
  localparam logic [2:0] UNIT_CP0  = 3'd6;
  localparam logic [2:0] UNIT_VEC  = 3'd7;

  logic dp_misc_clk;
  logic rst_n;

  logic               iu_rtu_ex1_alu_cmplt_dp;
  logic               iu_rtu_ex1_alu_inst_len;
  logic               iu_rtu_ex1_alu_inst_split;
  logic               iu_rtu_ex1_mul_cmplt_dp;
  logic               iu_rtu_ex1_bju_cmplt_dp;
  logic               iu_rtu_ex1_bju_inst_len;
  logic               iu_rtu_ex1_branch_inst;
  logic               iu_rtu_ex1_div_cmplt_dp;
  rtu_pkg::pc_t       iu_rtu_ex1_cur_pc;
  rtu_pkg::pc_t       iu_rtu_ex1_next_pc;
  logic               iu_rtu_depd_lsu_chgflow_vld;
  rtu_pkg::pc_t       iu_rtu_depd_lsu_next_pc;
  logic               lsu_rtu_ex1_cmplt_dp;
  logic               lsu_rtu_ex1_inst_len;
  logic               lsu_rtu_ex1_inst_split;
  logic               lsu_rtu_ex1_expt_vld;
  rtu_pkg::expt_vec_t lsu_rtu_ex1_expt_vec;
  rtu_pkg::pc_t       lsu_rtu_ex1_expt_tval;
  logic               cp0_rtu_ex1_cmplt_dp;
  logic               cp0_rtu_ex1_inst_len;
  logic               cp0_rtu_ex1_inst_split;
  logic               cp0_rtu_ex1_inst_mret;
  logic               cp0_rtu_ex1_inst_sret;
  logic               cp0_rtu_ex1_flush;
  logic               cp0_rtu_ex1_chgflw;
  rtu_pkg::pc_t       cp0_rtu_ex1_chgflw_pc;
  logic               cp0_rtu_ex1_expt_vld;
  rtu_pkg::expt_vec_t cp0_rtu_ex1_expt_vec;
  rtu_pkg::pc_t       cp0_rtu_ex1_expt_tval;
  logic               vpu_rtu_ex1_cmplt_dp;

  logic               rtu_iu_ex1_inst_len;
  logic               rtu_iu_ex1_inst_split;
  logic               dp_retire_ex2_vld;
  logic               dp_retire_ex2_inst_split;
  logic               dp_retire_ex2_inst_branch;
  logic               dp_retire_ex2_inst_mret;
  logic               dp_retire_ex2_inst_sret;
  logic               dp_retire_ex2_inst_flush;
  logic               dp_retire_ex2_inst_chgflw;
  rtu_pkg::pc_t       dp_retire_ex2_cur_pc;
  rtu_pkg::pc_t       dp_retire_ex2_next_pc;
  logic               dp_retire_ex2_inst_expt;
  rtu_pkg::expt_vec_t dp_retire_ex2_vec;
  rtu_pkg::pc_t       dp_retire_ex2_tval;

  integer seed;
  int     cycle_count = 0;
  int     test_cycle;
  int     error_count;

  // Expected ex2 state
  logic               exp_vld;
  logic               exp_split;
  logic               exp_branch;
  logic               exp_mret;
  logic               exp_sret;
  logic               exp_flush;
  logic               exp_chgflw;
  rtu_pkg::pc_t       exp_cur_pc;
  rtu_pkg::pc_t       exp_next_pc;

  // Expected trap state
  logic               exp_expt;
  rtu_pkg::expt_vec_t exp_vec;
  rtu_pkg::pc_t       exp_tval;

  rtu_dp_top UUT (.*);

  bind retire_ctrl rtu_dp_assertions u_rtu_dp_assertions (
    .dp_misc_clk (dp_misc_clk),
    .rst_n       (rst_n),
    .cmplt_src   (cmplt_src),
    .pipe_en     (pipe_en),
    .ex2_vld     (ex2_vld)
  );

  always #(CLK_PERIOD / 2) dp_misc_clk = ~dp_misc_clk;

  always @(posedge dp_misc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("tests failed");
      $fatal(1, "Simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  //--------------------------------------------------------------------------
  // Random sources
  //--------------------------------------------------------------------------

  function automatic logic [31:0] random_word();
    return $random(seed);
  endfunction

  function automatic rtu_pkg::pc_t random_pc();
    logic [63:0] w;
    w = {random_word(), random_word()};
    return w[`RTU_PA_WIDTH-1:0];
  endfunction

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  task automatic drive_unit_inputs(input logic [2:0] unit);
    logic [31:0] w;
    w = random_word();
    iu_rtu_ex1_alu_cmplt_dp     = (unit == UNIT_ALU);
    iu_rtu_ex1_mul_cmplt_dp     = (unit == UNIT_MUL);
    iu_rtu_ex1_bju_cmplt_dp     = (unit == UNIT_BJU);
    iu_rtu_ex1_div_cmplt_dp     = (unit == UNIT_DIV);
    lsu_rtu_ex1_cmplt_dp        = (unit == UNIT_LSU);
    cp0_rtu_ex1_cmplt_dp        = (unit == UNIT_CP0);
    vpu_rtu_ex1_cmplt_dp        = (unit == UNIT_VEC);
    iu_rtu_ex1_alu_inst_len     = w[0];
    iu_rtu_ex1_alu_inst_split   = w[1];
    iu_rtu_ex1_bju_inst_len     = w[2];
    iu_rtu_ex1_branch_inst      = w[3];
    lsu_rtu_ex1_inst_len        = w[4];
    lsu_rtu_ex1_inst_split      = w[5];
    lsu_rtu_ex1_expt_vld        = w[6];
    cp0_rtu_ex1_inst_len        = w[7];
    cp0_rtu_ex1_inst_split      = w[8];
    cp0_rtu_ex1_inst_mret       = w[9];
    cp0_rtu_ex1_inst_sret       = w[10];
    cp0_rtu_ex1_flush           = w[11];
    cp0_rtu_ex1_chgflw          = w[12];
    cp0_rtu_ex1_expt_vld        = w[13];
    iu_rtu_depd_lsu_chgflow_vld = w[14];
    lsu_rtu_ex1_expt_vec        = w[19:15];
    cp0_rtu_ex1_expt_vec        = w[24:20];
    iu_rtu_ex1_cur_pc           = random_pc();
    iu_rtu_ex1_next_pc          = random_pc();
    iu_rtu_depd_lsu_next_pc     = random_pc();
    lsu_rtu_ex1_expt_tval       = random_pc();
    cp0_rtu_ex1_chgflw_pc       = random_pc();
    cp0_rtu_ex1_expt_tval       = random_pc();
  endtask

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------

  function automatic logic expected_len(input logic [2:0] unit);
    case (unit)
      UNIT_ALU:                     return iu_rtu_ex1_alu_inst_len;
      UNIT_BJU:                     return iu_rtu_ex1_bju_inst_len;
      UNIT_LSU:                     return lsu_rtu_ex1_inst_len;
      UNIT_CP0:                     return cp0_rtu_ex1_inst_len;
      UNIT_MUL, UNIT_DIV, UNIT_VEC: return 1'b1;
      default:                      return 1'b0;
    endcase
  endfunction

  function automatic logic expected_split(input logic [2:0] unit);
    case (unit)
      UNIT_ALU: return iu_rtu_ex1_alu_inst_split;
      UNIT_LSU: return lsu_rtu_ex1_inst_split;
      UNIT_CP0: return cp0_rtu_ex1_inst_split;
      default:  return 1'b0;
    endcase
  endfunction

  // Next ex2 state from the inputs that the coming edge captures
  task automatic update_model(input logic [2:0] unit);
    exp_vld = (unit != UNIT_NONE);
    if (unit != UNIT_NONE) begin
      exp_split   = expected_split(unit);
      exp_branch  = (unit == UNIT_BJU) && iu_rtu_ex1_branch_inst;
      exp_mret    = (unit == UNIT_CP0) && cp0_rtu_ex1_inst_mret;
      exp_sret    = (unit == UNIT_CP0) && cp0_rtu_ex1_inst_sret;
      exp_flush   = (unit == UNIT_CP0) && cp0_rtu_ex1_flush;
      exp_chgflw  = (unit == UNIT_CP0) && cp0_rtu_ex1_chgflw;
      exp_cur_pc  = iu_rtu_ex1_cur_pc;
      exp_next_pc = exp_chgflw ? cp0_rtu_ex1_chgflw_pc : iu_rtu_ex1_next_pc;
    end
    if (unit == UNIT_CP0) begin
      exp_expt = cp0_rtu_ex1_expt_vld;
      exp_vec  = cp0_rtu_ex1_expt_vec;
      exp_tval = cp0_rtu_ex1_expt_tval;
    end else if (unit == UNIT_LSU) begin
      exp_expt = lsu_rtu_ex1_expt_vld;
      exp_vec  = lsu_rtu_ex1_expt_vec;
      exp_tval = lsu_rtu_ex1_expt_tval;
    end
  endtask

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------

  task automatic stop_on_mismatch();
    error_count = error_count + 1;
    $display("tests failed");
    $fatal(1, "Output mismatch at cycle %0d", test_cycle);
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("Error: %s cycle %0d expected %0h actual %0h",
               name, test_cycle, expected, actual);
      stop_on_mismatch();
    end
  endtask

  task automatic check_pc(input string name, input rtu_pkg::pc_t expected,
                          input rtu_pkg::pc_t actual);
    assert (actual === expected) else begin
      $display("Error: %s cycle %0d expected %0h actual %0h",
               name, test_cycle, expected, actual);
      stop_on_mismatch();
    end
  endtask

  task automatic check_vec(input string name, input rtu_pkg::expt_vec_t expected,
                           input rtu_pkg::expt_vec_t actual);
    assert (actual === expected) else begin
      $display("Error: %s cycle %0d expected %0h actual %0h",
               name, test_cycle, expected, actual);
      stop_on_mismatch();
    end
  endtask

  task automatic check_outputs(input logic [2:0] unit);
    rtu_pkg::pc_t next_pc;
    next_pc = iu_rtu_depd_lsu_chgflow_vld ? iu_rtu_depd_lsu_next_pc : exp_next_pc;
    check_bit("ex1_inst_len", expected_len(unit), rtu_iu_ex1_inst_len);
    check_bit("ex1_inst_split", expected_split(unit), rtu_iu_ex1_inst_split);
    check_bit("ex2_vld", exp_vld, dp_retire_ex2_vld);
    check_bit("ex2_inst_split", exp_split, dp_retire_ex2_inst_split);
    check_bit("ex2_inst_branch", exp_branch, dp_retire_ex2_inst_branch);
    check_bit("ex2_inst_mret", exp_mret, dp_retire_ex2_inst_mret);
    check_bit("ex2_inst_sret", exp_sret, dp_retire_ex2_inst_sret);
    check_bit("ex2_inst_flush", exp_flush, dp_retire_ex2_inst_flush);
    check_bit("ex2_inst_chgflw", exp_chgflw, dp_retire_ex2_inst_chgflw);
    check_pc("ex2_cur_pc", exp_cur_pc, dp_retire_ex2_cur_pc);
    check_pc("ex2_next_pc", next_pc, dp_retire_ex2_next_pc);
    check_bit("ex2_inst_expt", exp_expt, dp_retire_ex2_inst_expt);
    check_vec("ex2_vec", exp_vec, dp_retire_ex2_vec);
    check_pc("ex2_tval", exp_tval, dp_retire_ex2_tval);
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    logic [31:0] w;
    logic [2:0]  unit;
    seed        = 14382;
    error_count = 0;
    test_cycle  = 0;
    dp_misc_clk = 1'b0;
    rst_n       = 1'b0;
    drive_unit_inputs(UNIT_NONE);
    {exp_vld, exp_split, exp_branch, exp_mret, exp_sret, exp_flush, exp_chgflw} = '0;
    exp_cur_pc  = '0;
    exp_next_pc = '0;
    exp_expt    = 1'b0;
    exp_vec     = '0;
    exp_tval    = '0;

    repeat (RESET_CYCLES) @(posedge dp_misc_clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge dp_misc_clk);
      #DRIVE_DELAY;
      test_cycle = i;
      w          = random_word();
      unit       = w[2:0];
      drive_unit_inputs(unit);
      // Mid-cycle, ex1 and ex2 outputs are settled
      @(negedge dp_misc_clk);
      check_outputs(unit);
      update_model(unit);
    end

    if (error_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "Run ended with %0d mismatches", error_count);
    end
  end

endmodule

//--- project.f
+incdir+common
common/rtu_pkg.sv
logic/retire_ctrl.sv
logic/cmplt_decode.sv
logic/pc_select.sv
trap/trap_capture.sv
logic/rtu_dp_top.sv
verification/rtu_dp_assertions.sv
verification/rtu_dp_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the retire datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module rtu_dp_tb \
  && ./obj_dir/Vrtu_dp_tb > sim.log 2>&1 \
  || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null

grep -qx "all tests passed" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
